// ==== design/rs_pkg.sv ====
/*
 * Shared widths, opcode and functional-unit enums for the issue cluster
 * Dispatch, load, issue and common data bus structs
 */

package rs_pkg;

	localparam int data_width = 64;                // Operand and result width
	localparam int tag_bits   = 5;                 // Destination tag width, 32 in flight

	typedef enum logic [2:0]
	{
		OP_ADD = 3'd0,                             // a + b
		OP_SUB = 3'd1,                             // a - b
		OP_AND = 3'd2,                             // a & b
		OP_XOR = 3'd3,                             // a ^ b
		OP_MUL = 3'd4                              // Low half of a * b
	} op_code_t;

	typedef enum logic
	{
		FU_ALU = 1'b0,                             // Single-cycle ALU
		FU_MUL = 1'b1                              // Iterative multiplier
	} fu_select_t;

	// One instruction as handed in by the dispatcher
	typedef struct packed
	{
		op_code_t                op;
		logic [tag_bits-1:0]     dest_tag;         // Tag of the result
		logic [data_width-1:0]   opa;              // Value, or tag in low bits
		logic                    opa_valid;        // Set when opa is a value
		logic [data_width-1:0]   opb;              // Value, or tag in low bits
		logic                    opb_valid;        // Set when opb is a value
	} dispatch_packet_t;

	typedef struct packed
	{
		dispatch_packet_t        pkt;              // Instruction as dispatched
		fu_select_t              fu;               // Decoded unit class
	} rs_load_t;

	typedef struct packed
	{
		op_code_t                op;
		logic [tag_bits-1:0]     dest_tag;
		logic [data_width-1:0]   opa;
		logic [data_width-1:0]   opb;
	} issue_packet_t;

	typedef struct packed
	{
		logic                    valid;            // Broadcast this cycle
		logic [tag_bits-1:0]     tag;              // Tag of the result
		logic [data_width-1:0]   value;            // Result value
	} cdb_t;

endpackage

// ==== design/dispatch_port.sv ====
/*
 * Four-phase req/ack receiver for the dispatcher
 * Decodes the unit class and registers one load into the station
 */
`timescale 1ns/1ps

module dispatch_port
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      dispatch_req,     // Held high with a stable packet
	input  rs_pkg::dispatch_packet_t  dispatch_packet,
	output logic                      dispatch_ack,
	input  logic                      station_free,     // Some entry is free
	output logic                      load_valid,       // One-cycle load pulse
	output rs_pkg::rs_load_t          load_data
);
	import rs_pkg::*;

	typedef enum logic
	{
		IDLE,                                          // Waiting for req
		ACKED                                          // Ack high until req drops
	} port_state_t;

	port_state_t state;

	always_ff @(posedge clock)
	begin
		load_valid <= 1'b0;                            // Pulse by default
		if (reset)
		begin
			state        <= IDLE;
			dispatch_ack <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (dispatch_req && station_free)  // Full station holds off ack
					begin
						load_valid   <= 1'b1;
						dispatch_ack <= 1'b1;
						state        <= ACKED;
					end
				end
				ACKED:
				begin
					if (!dispatch_req)                 // Return to zero
					begin
						dispatch_ack <= 1'b0;
						state        <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Payload capture, taken with the accepting edge
	always_ff @(posedge clock)
	begin
		if (state == IDLE && dispatch_req)
		begin
			load_data.pkt <= dispatch_packet;
			load_data.fu  <= (dispatch_packet.op == OP_MUL) ? FU_MUL : FU_ALU;
		end
	end

	// Req still up in the cycle ack rises
	assert property (@(posedge clock) disable iff (reset)
		$rose(dispatch_ack) |-> dispatch_req);

endmodule

// ==== design/rs_entry.sv ====
/*
 * One reservation-station entry
 * Operand capture by tag from two CDBs, readiness split by unit class
 */
`timescale 1ns/1ps

module rs_entry
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   load,           // Take load_data this edge
	input  rs_pkg::rs_load_t       load_data,
	input  rs_pkg::cdb_t           cdb1,           // ALU results
	input  rs_pkg::cdb_t           cdb2,           // Multiplier results
	input  logic                   issue,          // Sent to a unit, frees entry
	output logic                   ready_alu,
	output logic                   ready_mul,
	output logic                   free,
	output rs_pkg::issue_packet_t  entry
);
	import rs_pkg::*;

	logic      in_use;                             // Entry holds an instruction
	rs_load_t  slot;                               // Held instruction
	logic      operands_ready;                     // Both operands are values

	// Replace a waiting operand with a matching broadcast
	function automatic logic [data_width:0] snoop_operand
	(
		input logic [data_width-1:0] value,
		input logic                  valid,
		input cdb_t                  bus1,
		input cdb_t                  bus2
	);
		logic [data_width:0] result;
		result = {valid, value};
		if (!valid && bus1.valid && bus1.tag == value[tag_bits-1:0])
			result = {1'b1, bus1.value};
		else if (!valid && bus2.valid && bus2.tag == value[tag_bits-1:0])
			result = {1'b1, bus2.value};
		return result;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Status and issue view
	//////////////////////////////////////////////////////////////////////

	assign free           = !in_use;
	assign operands_ready = in_use && slot.pkt.opa_valid && slot.pkt.opb_valid;
	assign ready_alu      = operands_ready && (slot.fu == FU_ALU);
	assign ready_mul      = operands_ready && (slot.fu == FU_MUL);

	assign entry.op       = slot.pkt.op;
	assign entry.dest_tag = slot.pkt.dest_tag;
	assign entry.opa      = slot.pkt.opa;
	assign entry.opb      = slot.pkt.opb;

	//////////////////////////////////////////////////////////////////////
	// Occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			in_use <= 1'b0;
		else if (load)
			in_use <= 1'b1;
		else if (issue)
			in_use <= 1'b0;                        // Handed to a unit
	end

	// Instruction and operand capture
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			slot.pkt.op       <= load_data.pkt.op;
			slot.pkt.dest_tag <= load_data.pkt.dest_tag;
			slot.fu           <= load_data.fu;
			{slot.pkt.opa_valid, slot.pkt.opa} <= snoop_operand(load_data.pkt.opa,
				load_data.pkt.opa_valid, cdb1, cdb2);  // Same-cycle broadcast taken too
			{slot.pkt.opb_valid, slot.pkt.opb} <= snoop_operand(load_data.pkt.opb,
				load_data.pkt.opb_valid, cdb1, cdb2);
		end
		else if (in_use)
		begin
			{slot.pkt.opa_valid, slot.pkt.opa} <= snoop_operand(slot.pkt.opa,
				slot.pkt.opa_valid, cdb1, cdb2);       // Wakeup from either bus
			{slot.pkt.opb_valid, slot.pkt.opb} <= snoop_operand(slot.pkt.opb,
				slot.pkt.opb_valid, cdb1, cdb2);
		end
	end

	// Allocation picks free entries only
	assert property (@(posedge clock) disable iff (reset)
		load |-> !in_use);

	// Selection only issues an entry that was ready
	assert property (@(posedge clock) disable iff (reset)
		issue |-> (ready_alu || ready_mul));

endmodule

// ==== design/rs_station.sv ====
/*
 * Reservation station built from rs_entries entries
 * Lowest-index free allocation and lowest-index issue per unit
 */
`timescale 1ns/1ps

module rs_station
#(
	parameter int rs_entries = 4                   // Number of entries, 2 to 8
)
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   load_valid,     // Load pulse from dispatch
	input  rs_pkg::rs_load_t       load_data,
	input  rs_pkg::cdb_t           cdb1,
	input  rs_pkg::cdb_t           cdb2,
	output logic                   station_free,   // Any entry free
	input  logic                   mult_available, // Multiplier idle
	output logic                   alu_issue_valid,
	output rs_pkg::issue_packet_t  alu_issue,
	output logic                   mult_issue_valid,
	output rs_pkg::issue_packet_t  mult_issue
);
	import rs_pkg::*;

	localparam int idx_bits = (rs_entries > 1) ? $clog2(rs_entries) : 1;

	logic [rs_entries-1:0]  free;                  // Per entry status
	logic [rs_entries-1:0]  ready_alu;
	logic [rs_entries-1:0]  ready_mul;
	logic [rs_entries-1:0]  load_vec;              // One-hot load
	logic [rs_entries-1:0]  issue_vec;             // Issue pulses back to entries
	issue_packet_t          entry_pkt [rs_entries];
	logic [idx_bits-1:0]    free_idx;              // Lowest free entry
	logic [idx_bits-1:0]    alu_idx;               // Lowest ready ALU entry
	logic [idx_bits-1:0]    mul_idx;               // Lowest ready multiply entry

	//////////////////////////////////////////////////////////////////////
	// Priority selection
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		free_idx = '0;
		alu_idx  = '0;
		mul_idx  = '0;
		for (int i = rs_entries - 1; i >= 0; i--)  // Downward scan, lowest wins
		begin
			if (free[i])
				free_idx = idx_bits'(i);
			if (ready_alu[i])
				alu_idx = idx_bits'(i);
			if (ready_mul[i])
				mul_idx = idx_bits'(i);
		end
	end

	assign station_free     = |free;
	assign alu_issue_valid  = |ready_alu;          // ALU always accepts
	assign mult_issue_valid = (|ready_mul) && mult_available;
	assign alu_issue        = entry_pkt[alu_idx];
	assign mult_issue       = entry_pkt[mul_idx];

	always_comb
	begin
		for (int i = 0; i < rs_entries; i++)
		begin
			load_vec[i]  = load_valid && (free_idx == idx_bits'(i));
			issue_vec[i] = (alu_issue_valid && (alu_idx == idx_bits'(i)))
				|| (mult_issue_valid && (mul_idx == idx_bits'(i)));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Entry array
	//////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < rs_entries; g++)
	begin : gen_entry
		rs_entry rs_entry_inst
		(
			.clock     (clock),
			.reset     (reset),
			.load      (load_vec[g]),
			.load_data (load_data),                // Shared load bus
			.cdb1      (cdb1),
			.cdb2      (cdb2),
			.issue     (issue_vec[g]),
			.ready_alu (ready_alu[g]),
			.ready_mul (ready_mul[g]),
			.free      (free[g]),
			.entry     (entry_pkt[g])
		);
	end

	// Dispatch checked fullness one edge earlier, nothing may have taken it since
	assert property (@(posedge clock) disable iff (reset)
		load_valid |-> station_free);

endmodule

// ==== design/alu_unit.sv ====
/*
 * Single-cycle ALU with add, subtract, and, xor
 * Result and tag registered onto CDB1
 */
`timescale 1ns/1ps

module alu_unit
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issue_valid,
	input  rs_pkg::issue_packet_t  issue,
	output rs_pkg::cdb_t           cdb1
);
	import rs_pkg::*;

	logic [data_width-1:0] result;                 // Combinational result

	always_comb
	begin
		case (issue.op)
			OP_ADD:  result = issue.opa + issue.opb;
			OP_SUB:  result = issue.opa - issue.opb;
			OP_AND:  result = issue.opa & issue.opb;
			OP_XOR:  result = issue.opa ^ issue.opb;
			default: result = '0;                  // Multiply goes elsewhere
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			cdb1.valid <= 1'b0;
		else
			cdb1.valid <= issue_valid;             // One-cycle broadcast
		cdb1.tag   <= issue.dest_tag;
		cdb1.value <= result;
	end

endmodule

// ==== design/mult_unit.sv ====
/*
 * Iterative radix-16 multiplier, low 64 bits of the product
 * 16 shift-add steps, then one broadcast cycle on CDB2
 */
`timescale 1ns/1ps

module mult_unit
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,          // Accept issue this edge
	input  rs_pkg::issue_packet_t  issue,
	output logic                   mult_available,
	output rs_pkg::cdb_t           cdb2
);
	import rs_pkg::*;

	typedef enum logic [1:0]
	{
		IDLE,                                      // No operation
		RUN,                                       // Shift-add steps
		DONE                                       // Broadcasting result
	} mult_state_t;

	mult_state_t            state;
	logic [3:0]             step_count;            // Digit being added
	logic [data_width-1:0]  multiplicand;          // Shifts left by 4
	logic [data_width-1:0]  multiplier;            // Shifts right by 4
	logic [data_width-1:0]  acc;                   // Running sum
	logic [tag_bits-1:0]    tag_reg;               // Destination tag
	logic [data_width-1:0]  partial;               // Multiplicand times low digit

	assign mult_available = (state != RUN);        // Free again in the broadcast cycle
	assign partial        = multiplicand * data_width'(multiplier[3:0]);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state      <= IDLE;
			step_count <= '0;
			cdb2.valid <= 1'b0;
		end
		else
		begin
			cdb2.valid <= 1'b0;
			case (state)
				RUN:
				begin
					step_count <= step_count + 4'd1;
					if (step_count == 4'd15)       // Last digit
					begin
						cdb2.valid <= 1'b1;
						state      <= DONE;
					end
				end
				default:                           // IDLE and DONE both accept
				begin
					step_count <= '0;
					state      <= start ? RUN : IDLE;
				end
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clock)
	begin
		if (state != RUN && start)
		begin
			multiplicand <= issue.opa;
			multiplier   <= issue.opb;
			acc          <= '0;
			tag_reg      <= issue.dest_tag;
		end
		else if (state == RUN)
		begin
			acc          <= acc + partial;
			multiplicand <= multiplicand << 4;
			multiplier   <= multiplier >> 4;
		end
		cdb2.tag   <= tag_reg;
		cdb2.value <= acc + partial;               // Taken on the last step
	end

	// Station must hold a multiply while a run is in progress
	assert property (@(posedge clock) disable iff (reset)
		start |-> (state != RUN));

endmodule

// ==== design/rs_cluster.sv ====
/*
 * Issue cluster top level
 * Dispatch port, reservation station, ALU and multiplier
 */
`timescale 1ns/1ps

module rs_cluster
#(
	parameter int rs_entries = 4                   // Station depth
)
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      dispatch_req,
	input  rs_pkg::dispatch_packet_t  dispatch_packet,
	output logic                      dispatch_ack,
	output rs_pkg::cdb_t              cdb1,         // ALU results
	output rs_pkg::cdb_t              cdb2          // Multiplier results
);
	import rs_pkg::*;

	logic           load_valid;                    // Dispatch to station
	rs_load_t       load_data;
	logic           station_free;
	logic           mult_available;                // Multiplier to station
	logic           alu_issue_valid;               // Station to units
	issue_packet_t  alu_issue;
	logic           mult_issue_valid;
	issue_packet_t  mult_issue;

	dispatch_port dispatch_port_inst
	(
		.clock           (clock),
		.reset           (reset),
		.dispatch_req    (dispatch_req),
		.dispatch_packet (dispatch_packet),
		.dispatch_ack    (dispatch_ack),
		.station_free    (station_free),
		.load_valid      (load_valid),
		.load_data       (load_data)
	);

	rs_station #(.rs_entries(rs_entries)) rs_station_inst
	(
		.clock            (clock),
		.reset            (reset),
		.load_valid       (load_valid),
		.load_data        (load_data),
		.cdb1             (cdb1),
		.cdb2             (cdb2),
		.station_free     (station_free),
		.mult_available   (mult_available),
		.alu_issue_valid  (alu_issue_valid),
		.alu_issue        (alu_issue),
		.mult_issue_valid (mult_issue_valid),
		.mult_issue       (mult_issue)
	);

	alu_unit alu_unit_inst
	(
		.clock       (clock),
		.reset       (reset),
		.issue_valid (alu_issue_valid),
		.issue       (alu_issue),
		.cdb1        (cdb1)
	);

	mult_unit mult_unit_inst
	(
		.clock          (clock),
		.reset          (reset),
		.start          (mult_issue_valid),
		.issue          (mult_issue),
		.mult_available (mult_available),
		.cdb2           (cdb2)
	);

endmodule

// ==== tests/rs_checker.sv ====
/*
 * Scoreboard for the issue cluster
 * Reference result function, tag-to-value table, CDB comparison
 * Per-test and closing report lines, cycle limit
 */
`timescale 1ns/1ps

module rs_checker
#(
	parameter int timeout_cycles = 1000            // Cycle limit for the whole run
)
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      dispatch_req,
	input  rs_pkg::dispatch_packet_t  dispatch_packet,
	input  logic                      dispatch_ack,
	input  rs_pkg::cdb_t              cdb1,
	input  rs_pkg::cdb_t              cdb2,
	output logic                      timed_out
);
	import rs_pkg::*;

	localparam int tag_count = 2 ** tag_bits;

	logic [data_width-1:0]  expected_value [tag_count];  // Result per tag, program order
	logic                   pending [tag_count];         // Dispatched, not yet broadcast
	logic                   ack_prev = 1'b0;             // Ack seen the edge before
	int                     cycle_count = 0;
	int                     error_count = 0;
	int                     check_count = 0;
	int                     outstanding = 0;
	int                     test_count  = 0;
	int                     test_checks = 0;
	int                     test_errors = 0;
	string                  test_name   = "reset";

	// Expected result of one instruction
	function automatic logic [data_width-1:0] reference_result
	(
		input op_code_t              op,
		input logic [data_width-1:0] a,
		input logic [data_width-1:0] b
	);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_XOR:  return a ^ b;
			OP_MUL:  return a * b;                     // Low half only
			default: return '0;
		endcase
	endfunction

	// Value operand as is, tag operand from the table
	function automatic logic [data_width-1:0] resolve_operand
	(
		input logic [data_width-1:0] operand,
		input logic                  valid
	);
		if (valid)
			return operand;
		return expected_value[operand[tag_bits-1:0]];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////////////////////////

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		test_count++;
		$display("test %s: %0d results checked, %0d errors", test_name, test_checks,
			test_errors);
	endtask

	// Failures found by the stimulus side
	task automatic report_failure(input string text);
		error_count++;
		test_errors++;
		$display("Error in test %s: %s", test_name, text);
	endtask

	task automatic print_summary();
		$display("%0d tests, %0d results checked, %0d errors, %0d results missing",
			test_count, check_count, error_count, outstanding);
	endtask

	// One bus, one broadcast
	task automatic check_bus(input cdb_t bus, input string bus_name);
		if (bus.valid)
		begin
			if (!pending[bus.tag])
			begin
				error_count++;
				test_errors++;
				$display("Error in test %s: %s broadcast tag %0d, which has no result pending",
					test_name, bus_name, bus.tag);
			end
			else
			begin
				pending[bus.tag] = 1'b0;               // Retired
				outstanding--;
				check_count++;
				test_checks++;
				if (bus.value !== expected_value[bus.tag])
				begin
					error_count++;
					test_errors++;
					$display("ERR %s tag %0d expected %h actual %h", test_name, bus.tag,
						expected_value[bus.tag], bus.value);
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitor
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin
		if (reset)
		begin
			timed_out   <= 1'b0;
			ack_prev     = 1'b0;
			cycle_count  = 0;
			for (int t = 0; t < tag_count; t++)
				pending[t] = 1'b0;
		end
		else
		begin
			cycle_count++;
			if (cycle_count == timeout_cycles)
			begin
				$display("Run stopped after %0d cycles with %0d results still missing",
					cycle_count, outstanding);
				timed_out <= 1'b1;
			end
			check_bus(cdb1, "cdb1");                   // Retire before new dispatch
			check_bus(cdb2, "cdb2");
			if (dispatch_req && dispatch_ack && !ack_prev)  // First cycle of a completed dispatch
			begin
				expected_value[dispatch_packet.dest_tag] = reference_result(dispatch_packet.op,
					resolve_operand(dispatch_packet.opa, dispatch_packet.opa_valid),
					resolve_operand(dispatch_packet.opb, dispatch_packet.opb_valid));
				pending[dispatch_packet.dest_tag] = 1'b1;
				outstanding++;
			end
			ack_prev = dispatch_ack;
		end
	end

endmodule

// ==== tests/tb_rs_cluster.sv ====
/*
 * Testbench for the issue cluster
 * Clock, reset, four-phase dispatch, directed and random tests
 */
`timescale 1ns/1ps

module tb_rs_cluster;
	import rs_pkg::*;

	localparam int rs_entries     = 4;
	localparam int total_instr    = 57;             // 4 + 2 + 4 + 7 + 40
	localparam int timeout_cycles = total_instr * 24 + 200;
	localparam int clock_period   = 40;
	localparam int tag_count      = 2 ** tag_bits;

	logic              clock;
	logic              reset;
	logic              dispatch_req;
	dispatch_packet_t  dispatch_packet;
	logic              dispatch_ack;
	cdb_t              cdb1;
	cdb_t              cdb2;
	logic              timed_out;

	int    cycle = 0;                               // Counted on falling edges
	logic  inflight [tag_count];                    // Dispatched, not yet broadcast
	int    earliest [tag_count];                    // Lower bound of broadcast edge
	int    inflight_count = 0;
	int    last_wait = 0;                           // Cycles req waited for ack

	initial
		clock = 1'b0;

	always #(clock_period / 2) clock = ~clock;

	rs_cluster #(.rs_entries(rs_entries)) rs_cluster_inst
	(
		.clock           (clock),
		.reset           (reset),
		.dispatch_req    (dispatch_req),
		.dispatch_packet (dispatch_packet),
		.dispatch_ack    (dispatch_ack),
		.cdb1            (cdb1),
		.cdb2            (cdb2)
	);

	rs_checker #(.timeout_cycles(timeout_cycles)) rs_checker_inst
	(
		.clock           (clock),
		.reset           (reset),
		.dispatch_req    (dispatch_req),
		.dispatch_packet (dispatch_packet),
		.dispatch_ack    (dispatch_ack),
		.cdb1            (cdb1),
		.cdb2            (cdb2),
		.timed_out       (timed_out)
	);

	// Broadcasts retire tags, seen mid-cycle
	always @(negedge clock)
	begin
		cycle++;
		if (cdb1.valid === 1'b1 && inflight[cdb1.tag])
		begin
			inflight[cdb1.tag] = 1'b0;
			inflight_count--;
		end
		if (cdb2.valid === 1'b1 && inflight[cdb2.tag])
		begin
			inflight[cdb2.tag] = 1'b0;
			inflight_count--;
		end
	end

	always @(posedge clock)
	begin
		if (timed_out === 1'b1)
		begin
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [data_width-1:0] rand_value();
		return {$urandom, $urandom};
	endfunction

	function automatic dispatch_packet_t make_packet
	(
		input op_code_t              op,
		input int                    dest,
		input logic [data_width-1:0] a,
		input logic                  a_valid,
		input logic [data_width-1:0] b,
		input logic                  b_valid
	);
		dispatch_packet_t pkt;
		pkt.op        = op;
		pkt.dest_tag  = tag_bits'(dest);
		pkt.opa       = a;
		pkt.opa_valid = a_valid;
		pkt.opb       = b;
		pkt.opb_valid = b_valid;
		return pkt;
	endfunction

	// Tag operand, zero extended
	function automatic logic [data_width-1:0] tag_operand(input int tag);
		return data_width'(tag);
	endfunction

	// Earliest broadcast edge of a consumer woken by producer_edge
	function automatic int wake_bound(input op_code_t op, input int producer_edge);
		return producer_edge + ((op == OP_MUL) ? 18 : 2);
	endfunction

	// Four-phase transfer of one instruction
	task automatic send_instruction(input dispatch_packet_t pkt);
		int ack_edge;
		int bound;
		dispatch_packet <= pkt;
		dispatch_req    <= 1'b1;
		last_wait        = 0;
		@(posedge clock);
		while (!dispatch_ack)
		begin
			last_wait++;
			@(posedge clock);
		end
		ack_edge = cycle - 1;                       // Ack rose one edge ago
		bound    = ack_edge + ((pkt.op == OP_MUL) ? 19 : 3);
		if (!pkt.opa_valid && wake_bound(pkt.op, earliest[pkt.opa[tag_bits-1:0]]) > bound)
			bound = wake_bound(pkt.op, earliest[pkt.opa[tag_bits-1:0]]);
		if (!pkt.opb_valid && wake_bound(pkt.op, earliest[pkt.opb[tag_bits-1:0]]) > bound)
			bound = wake_bound(pkt.op, earliest[pkt.opb[tag_bits-1:0]]);
		earliest[pkt.dest_tag] = bound;
		inflight[pkt.dest_tag] = 1'b1;
		inflight_count++;
		dispatch_req <= 1'b0;                       // Return to zero
		@(posedge clock);
		while (dispatch_ack)
			@(posedge clock);
	endtask

	// Wait until every result is out, then let the checker catch up
	task automatic drain();
		while (inflight_count != 0)
			@(posedge clock);
		repeat (2) @(posedge clock);
	endtask

	// Tag with no result pending
	function automatic int free_tag();
		int tags[$];
		for (int t = 0; t < tag_count; t++)
			if (!inflight[t])
				tags.push_back(t);
		return tags[$urandom_range(0, tags.size() - 1)];
	endfunction

	// Value, or a pending tag that cannot broadcast before the load lands
	task automatic pick_operand(output logic [data_width-1:0] value, output logic valid);
		int candidates[$];
		value = rand_value();
		valid = 1'b1;
		if (inflight_count < rs_entries && $urandom_range(0, 2) == 0)  // Free entry certain
		begin
			for (int t = 0; t < tag_count; t++)
				if (inflight[t] && earliest[t] >= cycle + 4)
					candidates.push_back(t);
			if (candidates.size() > 0)
			begin
				value = tag_operand(candidates[$urandom_range(0, candidates.size() - 1)]);
				valid = 1'b0;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		logic                  a_valid;
		logic                  b_valid;
		op_code_t              op;
		void'($urandom(32'h3d));
		reset           = 1'b1;
		dispatch_req    = 1'b0;
		dispatch_packet = '0;
		for (int t = 0; t < tag_count; t++)
		begin
			inflight[t] = 1'b0;
			earliest[t] = 0;
		end
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		// Independent ALU ops
		rs_checker_inst.start_test("alu_values");
		send_instruction(make_packet(OP_ADD, 1, rand_value(), 1'b1, rand_value(), 1'b1));
		send_instruction(make_packet(OP_SUB, 2, rand_value(), 1'b1, rand_value(), 1'b1));
		send_instruction(make_packet(OP_AND, 3, rand_value(), 1'b1, rand_value(), 1'b1));
		send_instruction(make_packet(OP_XOR, 4, rand_value(), 1'b1, rand_value(), 1'b1));
		drain();
		rs_checker_inst.end_test();

		// Second multiply waits for the first
		rs_checker_inst.start_test("mul_serial");
		send_instruction(make_packet(OP_MUL, 5, rand_value(), 1'b1, rand_value(), 1'b1));
		send_instruction(make_packet(OP_MUL, 6, rand_value(), 1'b1, rand_value(), 1'b1));
		drain();
		rs_checker_inst.end_test();

		// Multiply, ALU on it, multiply on that, ALU on the last
		rs_checker_inst.start_test("dep_chain");
		send_instruction(make_packet(OP_MUL, 7, rand_value(), 1'b1, rand_value(), 1'b1));
		send_instruction(make_packet(OP_ADD, 8, tag_operand(7), 1'b0, rand_value(), 1'b1));
		send_instruction(make_packet(OP_MUL, 9, tag_operand(8), 1'b0, rand_value(), 1'b1));
		send_instruction(make_packet(OP_SUB, 10, rand_value(), 1'b1, tag_operand(9), 1'b0));
		drain();
		rs_checker_inst.end_test();

		// Five long waiters against four entries
		rs_checker_inst.start_test("station_full");
		send_instruction(make_packet(OP_MUL, 11, rand_value(), 1'b1, rand_value(), 1'b1));
		send_instruction(make_packet(OP_MUL, 12, tag_operand(11), 1'b0, rand_value(), 1'b1));
		send_instruction(make_packet(OP_XOR, 13, tag_operand(12), 1'b0, rand_value(), 1'b1));
		send_instruction(make_packet(OP_ADD, 14, rand_value(), 1'b1, tag_operand(12), 1'b0));
		send_instruction(make_packet(OP_AND, 15, tag_operand(12), 1'b0, tag_operand(12), 1'b0));
		send_instruction(make_packet(OP_SUB, 16, tag_operand(12), 1'b0, rand_value(), 1'b1));
		send_instruction(make_packet(OP_ADD, 17, rand_value(), 1'b1, rand_value(), 1'b1));
		if (last_wait < 8)                          // Station was full of waiters
			rs_checker_inst.report_failure("ack was not held back while the station was full");
		drain();
		rs_checker_inst.end_test();

		// Random mix with dependencies on pending tags
		rs_checker_inst.start_test("random_mix");
		repeat (40)
		begin
			op = op_code_t'($urandom_range(0, 4));
			pick_operand(a, a_valid);
			pick_operand(b, b_valid);
			send_instruction(make_packet(op, free_tag(), a, a_valid, b, b_valid));
		end
		drain();
		rs_checker_inst.end_test();

		rs_checker_inst.print_summary();
		if (rs_checker_inst.error_count == 0 && rs_checker_inst.outstanding == 0
			&& rs_checker_inst.check_count == total_instr)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tb.f ====
design/rs_pkg.sv
design/dispatch_port.sv
design/rs_entry.sv
design/rs_station.sv
design/alu_unit.sv
design/mult_unit.sv
design/rs_cluster.sv
tests/rs_checker.sv
tests/tb_rs_cluster.sv

// ==== Makefile ====
# Verilator build for the issue cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_rs_cluster
SEED      ?= 61
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(SIM_BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
